//--- mmu_pkg.sv
package mmu_pkg;

  // ==========================================================
  // default geometry, top level passes these down as parameters
  // ==========================================================
  localparam int VADDR_W_DEF  = 20;   // virtual address bits
  localparam int PADDR_W_DEF  = 24;   // physical address bits
  localparam int OFFSET_W_DEF = 12;   // 4 KiB pages
  localparam int KEY_W_DEF    = 2;    // address-space key bits

  // ==========================================================
  // apb register map
  // ==========================================================
  localparam int APB_AW = 16;         // apb address width
  localparam int APB_DW = 32;         // apb data width

  localparam logic [APB_AW-1:0] CTRL_OFS = 16'h0000;  // control register
  localparam logic [APB_AW-1:0] STAT_OFS = 16'h0004;  // sticky status, write 1 clears

  // control register fields
  localparam int CTRL_EN_BIT  = 0;    // map enable
  localparam int CTRL_KEY_LSB = 4;    // key lives in bits 5:4

  // status register fields
  localparam int STAT_EXV = 0;        // execute violation seen
  localparam int STAT_RDV = 1;        // read violation seen
  localparam int STAT_WRV = 2;        // write violation seen
  localparam int STAT_W   = 3;        // number of status flags

  // table window
  localparam int TBL_SEL_BIT = 12;    // set -> access hits the map table
  localparam int TBL_IDX_LSB = 2;     // entry index starts at address bit 2

  // ==========================================================
  // map entry layout
  // ==========================================================
  // entry = {perm[2:0], ppn}, perm field sits on top
  localparam int PERM_X = 0;          // execute allowed
  localparam int PERM_W = 1;          // write allowed
  localparam int PERM_R = 2;          // read allowed
  localparam int PERM_FW = 3;         // width of the permission field

endpackage

//--- mmu_map_ram.sv
`timescale 1ns/1ns

// dual-port map table
// port a: config side, read/write, read-before-write
// port b: lookup side, read only
module mmu_map_ram #(
  parameter int VADDR_W  = mmu_pkg::VADDR_W_DEF,
  parameter int PADDR_W  = mmu_pkg::PADDR_W_DEF,
  parameter int OFFSET_W = mmu_pkg::OFFSET_W_DEF,
  parameter int KEY_W    = mmu_pkg::KEY_W_DEF,
  localparam int IDX_W   = KEY_W + VADDR_W - OFFSET_W,          // {key, vpn}
  localparam int ENT_W   = mmu_pkg::PERM_FW + PADDR_W - OFFSET_W  // {perm, ppn}
) (
  input  logic             clk_i,
  // configuration port
  input  logic             cfg_en_i,
  input  logic             cfg_we_i,
  input  logic [IDX_W-1:0] cfg_idx_i,
  input  logic [ENT_W-1:0] cfg_wdata_i,
  output logic [ENT_W-1:0] cfg_rdata_o,
  // lookup port
  input  logic             lk_en_i,
  input  logic [IDX_W-1:0] lk_idx_i,
  output logic [ENT_W-1:0] lk_rdata_o
);

  localparam int DEPTH = 1 << IDX_W;

  logic [ENT_W-1:0] mem_q [0:DEPTH-1];  // contents undefined after reset

  // config port, old data comes back on a write
  always_ff @(posedge clk_i) begin
    if (cfg_en_i) begin
      if (cfg_we_i) mem_q[cfg_idx_i] <= cfg_wdata_i;
      cfg_rdata_o <= mem_q[cfg_idx_i];
    end
  end

  // lookup port, sees the old entry on a same-cycle write
  always_ff @(posedge clk_i) begin
    if (lk_en_i) begin
      lk_rdata_o <= mem_q[lk_idx_i];
    end
  end

endmodule

//--- mmu_cfg_regs.sv
`timescale 1ns/1ns

// apb slave: control reg, sticky status reg and a window onto the map table
module mmu_cfg_regs #(
  parameter int VADDR_W  = mmu_pkg::VADDR_W_DEF,
  parameter int PADDR_W  = mmu_pkg::PADDR_W_DEF,
  parameter int OFFSET_W = mmu_pkg::OFFSET_W_DEF,
  parameter int KEY_W    = mmu_pkg::KEY_W_DEF,
  localparam int IDX_W   = KEY_W + VADDR_W - OFFSET_W,
  localparam int ENT_W   = mmu_pkg::PERM_FW + PADDR_W - OFFSET_W
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // apb slave
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [mmu_pkg::APB_AW-1:0] paddr_i,
  input  logic [mmu_pkg::APB_DW-1:0] pwdata_i,
  output logic [mmu_pkg::APB_DW-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // to the translation pipeline
  output logic                      map_en_o,
  output logic [KEY_W-1:0]          key_o,
  // map table config port
  output logic                      cfg_en_o,
  output logic                      cfg_we_o,
  output logic [IDX_W-1:0]          cfg_idx_o,
  output logic [ENT_W-1:0]          cfg_wdata_o,
  input  logic [ENT_W-1:0]          cfg_rdata_i,
  // fault pulses from the pipeline
  input  logic                      exv_i,
  input  logic                      rdv_i,
  input  logic                      wrv_i
);

  logic                       access;     // apb access phase
  logic                       tbl_sel;    // address falls in the table window
  logic                       tbl_rd;     // table read, needs a wait state
  logic                       ctrl_wr;
  logic                       stat_wr;
  logic                       rd_wait_q;  // table read data arrives next cycle
  logic                       map_en_q;
  logic [KEY_W-1:0]           key_q;
  logic [mmu_pkg::STAT_W-1:0] stat_q;
  logic [mmu_pkg::STAT_W-1:0] stat_set;
  logic [mmu_pkg::STAT_W-1:0] stat_clr;

  // ==========================================================
  // address decode
  // ==========================================================
  assign access  = psel_i & penable_i;
  assign tbl_sel = paddr_i[mmu_pkg::TBL_SEL_BIT];
  assign tbl_rd  = access & tbl_sel & ~pwrite_i;
  assign ctrl_wr = access & pwrite_i & (paddr_i == mmu_pkg::CTRL_OFS);
  assign stat_wr = access & pwrite_i & (paddr_i == mmu_pkg::STAT_OFS);

  // table port, index taken straight from the address (bits 11:2 by default)
  assign cfg_en_o    = access & tbl_sel & ~rd_wait_q;  // one strobe per access
  assign cfg_we_o    = access & tbl_sel & pwrite_i;
  assign cfg_idx_o   = paddr_i[mmu_pkg::TBL_IDX_LSB +: IDX_W];
  assign cfg_wdata_o = pwdata_i[ENT_W-1:0];            // upper bits dropped

  // everything but a table read finishes in the first access cycle
  assign pready_o  = access & (~tbl_rd | rd_wait_q);
  assign pslverr_o = 1'b0;

  always_ff @(posedge clk_i) begin
    if (rst_i) rd_wait_q <= 1'b0;
    else       rd_wait_q <= tbl_rd & ~rd_wait_q;  // high for exactly one cycle
  end

  // ==========================================================
  // control and status
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      map_en_q <= 1'b0;
      key_q    <= '0;
    end else if (ctrl_wr) begin
      map_en_q <= pwdata_i[mmu_pkg::CTRL_EN_BIT];
      key_q    <= pwdata_i[mmu_pkg::CTRL_KEY_LSB +: KEY_W];
    end
  end

  assign stat_set[mmu_pkg::STAT_EXV] = exv_i;
  assign stat_set[mmu_pkg::STAT_RDV] = rdv_i;
  assign stat_set[mmu_pkg::STAT_WRV] = wrv_i;
  assign stat_clr = {mmu_pkg::STAT_W{stat_wr}} & pwdata_i[mmu_pkg::STAT_W-1:0];  // w1c

  always_ff @(posedge clk_i) begin
    if (rst_i) stat_q <= '0;
    else       stat_q <= (stat_q & ~stat_clr) | stat_set;  // new fault beats the clear
  end

  assign map_en_o = map_en_q;
  assign key_o    = key_q;

  // read mux, zero outside a read access
  always_comb begin
    prdata_o = '0;
    if (access && !pwrite_i) begin
      if (tbl_sel) begin
        prdata_o[ENT_W-1:0] = cfg_rdata_i;  // entry, zero-extended
      end else if (paddr_i == mmu_pkg::CTRL_OFS) begin
        prdata_o[mmu_pkg::CTRL_EN_BIT]            = map_en_q;
        prdata_o[mmu_pkg::CTRL_KEY_LSB +: KEY_W] = key_q;
      end else if (paddr_i == mmu_pkg::STAT_OFS) begin
        prdata_o[mmu_pkg::STAT_W-1:0] = stat_q;
      end
    end
  end

endmodule

//--- mmu_xlate.sv
`timescale 1ns/1ns

// translation pipeline, fixed two cycle latency, one request per cycle
//   edge N   : stage 1 captures request, forms {key, vpn} index
//   edge N+1 : table read, request attributes move along with it
//   edge N+2 : stage 2 merges ppn, checks permissions, outputs registered
module mmu_xlate #(
  parameter int VADDR_W  = mmu_pkg::VADDR_W_DEF,
  parameter int PADDR_W  = mmu_pkg::PADDR_W_DEF,
  parameter int OFFSET_W = mmu_pkg::OFFSET_W_DEF,
  parameter int KEY_W    = mmu_pkg::KEY_W_DEF,
  localparam int IDX_W   = KEY_W + VADDR_W - OFFSET_W,
  localparam int ENT_W   = mmu_pkg::PERM_FW + PADDR_W - OFFSET_W
) (
  input  logic               clk_i,
  input  logic               rst_i,
  // request port
  input  logic               req_valid_i,
  input  logic [VADDR_W-1:0] req_addr_i,
  input  logic               req_wr_i,   // write intent
  input  logic               req_ex_i,   // instruction fetch
  // from the register block
  input  logic               map_en_i,
  input  logic [KEY_W-1:0]   key_i,
  // map table lookup port
  output logic               lk_en_o,
  output logic [IDX_W-1:0]   lk_idx_o,
  input  logic [ENT_W-1:0]   lk_rdata_i,
  // result
  output logic               pa_valid_o,
  output logic [PADDR_W-1:0] pa_o,
  output logic               pa_we_o,
  output logic               exv_o,      // execute violation
  output logic               rdv_o,      // read violation
  output logic               wrv_o       // write violation
);

  localparam int PPN_W = PADDR_W - OFFSET_W;

  // stage 1, request capture
  logic               s1_valid;
  logic               s1_wr;
  logic               s1_ex;
  logic               s1_map_en;
  logic [VADDR_W-1:0] s1_addr;
  logic [IDX_W-1:0]   s1_idx;

  // lined up with lk_rdata_i
  logic               s2_valid;
  logic               s2_wr;
  logic               s2_ex;
  logic               s2_map_en;
  logic [VADDR_W-1:0] s2_addr;

  logic [mmu_pkg::PERM_FW-1:0] perm;
  logic [PPN_W-1:0]            ppn;
  logic                        chk_x;
  logic                        chk_r;
  logic                        chk_w;
  logic                        fault;

  // ==========================================================
  // stage 1
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (rst_i) s1_valid <= 1'b0;
    else       s1_valid <= req_valid_i;
  end

  // attributes only mean something while s1_valid is set
  always_ff @(posedge clk_i) begin
    s1_wr     <= req_wr_i;
    s1_ex     <= req_ex_i;
    s1_map_en <= map_en_i;  // sampled with the request
    s1_addr   <= req_addr_i;
    s1_idx    <= {key_i, req_addr_i[VADDR_W-1:OFFSET_W]};
  end

  assign lk_en_o  = s1_valid;
  assign lk_idx_o = s1_idx;

  // keep address and attributes in step with the table output
  always_ff @(posedge clk_i) begin
    if (rst_i) s2_valid <= 1'b0;
    else       s2_valid <= s1_valid;
  end

  always_ff @(posedge clk_i) begin
    s2_wr     <= s1_wr;
    s2_ex     <= s1_ex;
    s2_map_en <= s1_map_en;
    s2_addr   <= s1_addr;
  end

  // ==========================================================
  // stage 2
  // ==========================================================
  assign perm = lk_rdata_i[ENT_W-1 -: mmu_pkg::PERM_FW];
  assign ppn  = lk_rdata_i[PPN_W-1:0];

  // one check per request: write, else execute, else read
  assign chk_w = s2_wr & ~perm[mmu_pkg::PERM_W];
  assign chk_x = ~s2_wr & s2_ex & ~perm[mmu_pkg::PERM_X];
  assign chk_r = ~s2_wr & ~s2_ex & ~perm[mmu_pkg::PERM_R];
  assign fault = s2_valid & s2_map_en & (chk_w | chk_x | chk_r);  // unmapped never faults

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pa_valid_o <= 1'b0;
      pa_we_o    <= 1'b0;
      exv_o      <= 1'b0;
      rdv_o      <= 1'b0;
      wrv_o      <= 1'b0;
    end else begin
      pa_valid_o <= s2_valid & ~fault;
      pa_we_o    <= s2_valid & s2_wr & ~fault;
      exv_o      <= s2_valid & s2_map_en & chk_x;  // single cycle pulses
      rdv_o      <= s2_valid & s2_map_en & chk_r;
      wrv_o      <= s2_valid & s2_map_en & chk_w;
    end
  end

  // payload, qualified by pa_valid_o
  always_ff @(posedge clk_i) begin
    if (s2_map_en) pa_o <= {ppn, s2_addr[OFFSET_W-1:0]};
    else           pa_o <= {{(PADDR_W-VADDR_W){1'b0}}, s2_addr};  // flat, zero-extended
  end

endmodule

//--- mmu_top.sv
`timescale 1ns/1ns

// mmu subsystem: apb register block, map table, translation pipeline
module mmu_top #(
  parameter int VADDR_W  = mmu_pkg::VADDR_W_DEF,
  parameter int PADDR_W  = mmu_pkg::PADDR_W_DEF,
  parameter int OFFSET_W = mmu_pkg::OFFSET_W_DEF,
  parameter int KEY_W    = mmu_pkg::KEY_W_DEF
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // apb slave
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [mmu_pkg::APB_AW-1:0] paddr_i,
  input  logic [mmu_pkg::APB_DW-1:0] pwdata_i,
  output logic [mmu_pkg::APB_DW-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // request port
  input  logic                      req_valid_i,
  input  logic [VADDR_W-1:0]        req_addr_i,
  input  logic                      req_wr_i,
  input  logic                      req_ex_i,
  // translation result
  output logic                      pa_valid_o,
  output logic [PADDR_W-1:0]        pa_o,
  output logic                      pa_we_o,
  output logic                      exv_o,
  output logic                      rdv_o,
  output logic                      wrv_o
);

  localparam int IDX_W = KEY_W + VADDR_W - OFFSET_W;
  localparam int ENT_W = mmu_pkg::PERM_FW + PADDR_W - OFFSET_W;

  logic             map_en;
  logic [KEY_W-1:0] key;
  logic             cfg_en;
  logic             cfg_we;
  logic [IDX_W-1:0] cfg_idx;
  logic [ENT_W-1:0] cfg_wdata;
  logic [ENT_W-1:0] cfg_rdata;
  logic             lk_en;
  logic [IDX_W-1:0] lk_idx;
  logic [ENT_W-1:0] lk_rdata;

  mmu_cfg_regs #(
    .VADDR_W(VADDR_W), .PADDR_W(PADDR_W), .OFFSET_W(OFFSET_W), .KEY_W(KEY_W)
  ) u_regs (
    .clk_i, .rst_i,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .map_en_o(map_en), .key_o(key),
    .cfg_en_o(cfg_en), .cfg_we_o(cfg_we), .cfg_idx_o(cfg_idx),
    .cfg_wdata_o(cfg_wdata), .cfg_rdata_i(cfg_rdata),
    .exv_i(exv_o), .rdv_i(rdv_o), .wrv_i(wrv_o)  // fault pulses feed the sticky flags
  );

  mmu_map_ram #(
    .VADDR_W(VADDR_W), .PADDR_W(PADDR_W), .OFFSET_W(OFFSET_W), .KEY_W(KEY_W)
  ) u_ram (
    .clk_i,
    .cfg_en_i(cfg_en), .cfg_we_i(cfg_we), .cfg_idx_i(cfg_idx),
    .cfg_wdata_i(cfg_wdata), .cfg_rdata_o(cfg_rdata),
    .lk_en_i(lk_en), .lk_idx_i(lk_idx), .lk_rdata_o(lk_rdata)
  );

  mmu_xlate #(
    .VADDR_W(VADDR_W), .PADDR_W(PADDR_W), .OFFSET_W(OFFSET_W), .KEY_W(KEY_W)
  ) u_xlate (
    .clk_i, .rst_i,
    .req_valid_i, .req_addr_i, .req_wr_i, .req_ex_i,
    .map_en_i(map_en), .key_i(key),
    .lk_en_o(lk_en), .lk_idx_o(lk_idx), .lk_rdata_i(lk_rdata),
    .pa_valid_o, .pa_o, .pa_we_o, .exv_o, .rdv_o, .wrv_o
  );

endmodule

//--- tb_mmu.sv
`timescale 1ns/1ns

module tb_mmu;

  localparam int VA_W  = mmu_pkg::VADDR_W_DEF;
  localparam int PA_W  = mmu_pkg::PADDR_W_DEF;
  localparam int OF_W  = mmu_pkg::OFFSET_W_DEF;
  localparam int K_W   = mmu_pkg::KEY_W_DEF;
  localparam int PPN_W = PA_W - OF_W;
  localparam int ENT_W = 3 + PPN_W;                 // {perm, ppn}
  localparam int IDX_W = K_W + VA_W - OF_W;         // {key, vpn}

  // expected result of one request
  typedef struct packed {
    int unsigned     due;                           // cycle count when it shows up
    logic            valid;
    logic            we;
    logic            exv;
    logic            rdv;
    logic            wrv;
    logic [PA_W-1:0] pa;
  } exp_t;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        psel_i, penable_i, pwrite_i;
  logic [15:0] paddr_i;
  logic [31:0] pwdata_i, prdata_o;
  logic        pready_o, pslverr_o;
  logic            req_valid_i, req_wr_i, req_ex_i;
  logic [VA_W-1:0] req_addr_i;
  logic            pa_valid_o, pa_we_o, exv_o, rdv_o, wrv_o;
  logic [PA_W-1:0] pa_o;

  logic        pready_s;                            // apb outputs taken at the rising edge
  logic        pslverr_s;
  logic [31:0] prdata_s;

  logic [ENT_W-1:0] tbl_m [0:(1<<IDX_W)-1];         // mirror of every entry written
  logic [31:0]      ctrl_m;                         // mirror of the control reg
  exp_t             exp_q [$];                      // predicted results in request order
  logic [31:0]      lfsr_q = 32'hfdb6;
  int unsigned      cyc = 0;                        // rising edges seen
  int               err_cnt = 0;
  int               tests_run = 0;
  int               tests_fail = 0;

  mmu_top #(
    .VADDR_W(VA_W), .PADDR_W(PA_W), .OFFSET_W(OF_W), .KEY_W(K_W)
  ) dut (.*);

  always #10 clk_i = ~clk_i;                         // 20 ns period
  always @(posedge clk_i) cyc <= cyc + 1;

  // apb outputs as the completing rising edge sees them
  always @(posedge clk_i) begin
    pready_s  <= pready_o;
    prdata_s  <= prdata_o;
    pslverr_s <= pslverr_o;
  end

  // ============================================================
  // helpers
  // ============================================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);                   // one step per bit
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  function automatic logic [15:0] tbl_addr(input logic [IDX_W-1:0] idx);
    return 16'h1000 | (16'(idx) << 2);              // bit 12 opens the table window
  endfunction

  // returns on the falling edge after the completing rising edge
  task automatic wait_ready(output int waits);
    waits = 0;
    @(negedge clk_i);                               // first access cycle now sampled
    while (!pready_s && waits < 8) begin            // bounded wait states
      waits++;
      @(negedge clk_i);
    end
    if (!pready_s) begin
      err_cnt++;
      $display("apb access to %0h timed out waiting for pready_o", paddr_i);
    end else begin
      expect_eq("pslverr_o", pslverr_s, 0);
    end
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
    int waits;
    @(negedge clk_i);
    psel_i = 1'b1;                                  // setup
    penable_i = 1'b0;
    pwrite_i = 1'b1;
    paddr_i = addr;
    pwdata_i = data;
    @(negedge clk_i);
    penable_i = 1'b1;                               // access
    wait_ready(waits);
    psel_i = 1'b0;
    penable_i = 1'b0;
    expect_eq("pready_o wait states", waits, 0);   // writes never stall
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output int waits);
    @(negedge clk_i);
    psel_i = 1'b1;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = addr;
    @(negedge clk_i);
    penable_i = 1'b1;
    wait_ready(waits);
    data = prdata_s;                                // taken on the completing edge
    psel_i = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic check_read(input logic [15:0] addr, input logic [31:0] exp, input int exp_waits);
    logic [31:0] data;
    int          waits;
    apb_read(addr, data, waits);
    expect_eq("prdata_o", data, exp);
    expect_eq("pready_o wait states", waits, exp_waits);
  endtask

  task automatic write_entry(input logic [IDX_W-1:0] idx, input logic [31:0] data);
    apb_write(tbl_addr(idx), data);
    tbl_m[idx] = data[ENT_W-1:0];                   // table keeps the low bits only
  endtask

  task automatic set_ctrl(input logic en, input logic [K_W-1:0] key);
    ctrl_m = '0;
    ctrl_m[mmu_pkg::CTRL_EN_BIT] = en;
    ctrl_m[mmu_pkg::CTRL_KEY_LSB +: K_W] = key;
    apb_write(mmu_pkg::CTRL_OFS, ctrl_m);
  endtask

  // drive one request and predict its result from the mirrors
  task automatic send_req(input logic [VA_W-1:0] addr, input logic wr, input logic ex);
    exp_t             e;
    logic [ENT_W-1:0] ent;
    logic [2:0]       perm;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_addr_i = addr;
    req_wr_i = wr;
    req_ex_i = ex;
    e = '0;
    e.due = cyc + 3;                                // sampled on the next edge and out two later
    e.valid = 1'b1;
    e.we = wr;
    e.pa = PA_W'(addr);                             // flat mapping
    if (ctrl_m[mmu_pkg::CTRL_EN_BIT]) begin
      ent  = tbl_m[{ctrl_m[mmu_pkg::CTRL_KEY_LSB +: K_W], addr[VA_W-1:OF_W]}];
      perm = ent[ENT_W-1 -: 3];
      e.pa = {ent[PPN_W-1:0], addr[OF_W-1:0]};
      if (wr)      e.wrv = ~perm[mmu_pkg::PERM_W];  // write wins
      else if (ex) e.exv = ~perm[mmu_pkg::PERM_X];
      else         e.rdv = ~perm[mmu_pkg::PERM_R];
      e.valid = ~(e.wrv | e.exv | e.rdv);
      e.we    = wr & e.valid;
    end
    exp_q.push_back(e);
  endtask

  task automatic stop_req();
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 32) begin
      n++;
      @(posedge clk_i);
    end
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d request results never came out", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_fail++;
      $display("test %0d %s: fail, %0d errors", tests_run, name, err_cnt - errs_before);
    end
  endtask

  // ============================================================
  // output checker samples on the falling edge where outputs are stable
  // ============================================================
  always @(negedge clk_i) begin : chk
    exp_t e;
    if (!rst_i) begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        e = exp_q.pop_front();
        expect_eq("pa_valid_o", pa_valid_o, e.valid);
        expect_eq("pa_we_o", pa_we_o, e.we);
        expect_eq("exv_o", exv_o, e.exv);
        expect_eq("rdv_o", rdv_o, e.rdv);
        expect_eq("wrv_o", wrv_o, e.wrv);
        if (e.valid) expect_eq("pa_o", pa_o, e.pa);  // pa_o only means something when valid
      end else begin
        expect_eq("pa_valid_o", pa_valid_o, 0);    // nothing due so outputs stay idle
        expect_eq("pa_we_o", pa_we_o, 0);
        expect_eq("exv_o", exv_o, 0);
        expect_eq("rdv_o", rdv_o, 0);
        expect_eq("wrv_o", wrv_o, 0);
      end
    end
  end

  // ============================================================
  // test sequence
  // ============================================================
  initial begin : main
    logic [31:0]      r;
    logic [31:0]      d;
    logic [IDX_W-1:0] idx_a [0:7];
    logic [7:0]       v;
    logic [2:0]       f_perm [0:2];
    logic             f_wr [0:2];
    logic             f_ex [0:2];
    int               f_bit [0:2];
    int               e0;
    f_perm = '{3'b011, 3'b101, 3'b110};             // no R, no W, no X
    f_wr   = '{1'b0, 1'b1, 1'b0};
    f_ex   = '{1'b0, 1'b0, 1'b1};
    f_bit  = '{mmu_pkg::STAT_RDV, mmu_pkg::STAT_WRV, mmu_pkg::STAT_EXV};
    rst_i = 1'b1;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    req_valid_i = 1'b0;
    req_addr_i = '0;
    req_wr_i = 1'b0;
    req_ex_i = 1'b0;
    ctrl_m = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    e0 = err_cnt;                                   // reset state
    check_read(mmu_pkg::CTRL_OFS, 0, 0);
    check_read(mmu_pkg::STAT_OFS, 0, 0);
    end_test("reset_state", e0);

    e0 = err_cnt;                                   // table window with one wait state on read
    for (int i = 0; i < 8; i++) begin
      rand_bits(IDX_W, r);
      idx_a[i] = r[IDX_W-1:0];
      rand_bits(32, d);
      write_entry(idx_a[i], d);
    end
    for (int i = 0; i < 8; i++) check_read(tbl_addr(idx_a[i]), tbl_m[idx_a[i]], 1);
    end_test("table_access", e0);

    e0 = err_cnt;                                   // map off gives flat addresses
    set_ctrl(1'b0, 2'd3);
    for (int i = 0; i < 6; i++) begin
      rand_bits(VA_W + 2, r);
      send_req(r[VA_W-1:0], r[VA_W], r[VA_W+1]);
    end
    stop_req();
    drain();
    end_test("map_disabled", e0);

    e0 = err_cnt;                                   // same page under two keys
    rand_bits(8, r);
    v = r[7:0];
    rand_bits(PPN_W, d);
    write_entry({2'd1, v}, {3'b111, d[PPN_W-1:0]});
    write_entry({2'd2, v}, {3'b111, ~d[PPN_W-1:0]});  // ppn differs from the key 1 entry
    rand_bits(OF_W, r);
    set_ctrl(1'b1, 2'd1);
    send_req({v, r[OF_W-1:0]}, 1'b0, 1'b0);
    send_req({v, r[OF_W-1:0]}, 1'b1, 1'b0);
    stop_req();
    drain();
    set_ctrl(1'b1, 2'd2);                           // other key selects the other entry
    send_req({v, r[OF_W-1:0]}, 1'b0, 1'b0);
    stop_req();
    drain();
    end_test("map_enabled_keys", e0);

    e0 = err_cnt;                                   // one fault kind per entry
    for (int i = 0; i < 3; i++) begin
      rand_bits(PPN_W, d);
      write_entry({2'd3, v ^ 8'(i)}, {f_perm[i], d[PPN_W-1:0]});
    end
    set_ctrl(1'b1, 2'd3);
    for (int i = 0; i < 3; i++) begin
      rand_bits(OF_W, r);
      send_req({v ^ 8'(i), r[OF_W-1:0]}, f_wr[i], f_ex[i]);
      stop_req();
      drain();
      check_read(mmu_pkg::STAT_OFS, 32'(1) << f_bit[i], 0);  // sticky flag
      apb_write(mmu_pkg::STAT_OFS, 32'(1) << f_bit[i]);      // write one clears
      check_read(mmu_pkg::STAT_OFS, 0, 0);
    end
    end_test("permission_faults", e0);

    e0 = err_cnt;                                   // back to back with mixed outcomes
    for (int i = 0; i < 12; i++) begin
      rand_bits(OF_W + 4, r);
      send_req({v ^ 8'(r[1:0] % 3), r[OF_W+1:2]}, r[OF_W+2], r[OF_W+3]);
    end
    stop_req();
    drain();
    apb_write(mmu_pkg::STAT_OFS, 32'h7);
    check_read(mmu_pkg::STAT_OFS, 0, 0);
    end_test("back_to_back", e0);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_fail, err_cnt);
    if (err_cnt == 0 && tests_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
mmu_pkg.sv
mmu_map_ram.sv
mmu_cfg_regs.sv
mmu_xlate.sv
mmu_top.sv
tb_mmu.sv

//--- Bender.yml
package:
  name: mmu

sources:
  # rtl
  - files:
      - mmu_pkg.sv
      - mmu_map_ram.sv
      - mmu_cfg_regs.sv
      - mmu_xlate.sv
      - mmu_top.sv
  # testbench
  - target: test
    files:
      - tb_mmu.sv
